//--- include/bit_diff_params.svh
`ifndef BIT_DIFF_PARAMS_SVH
`define BIT_DIFF_PARAMS_SVH

////////////////////////////////////////////////////////////
// Bit-difference calculator sizing
////////////////////////////////////////////////////////////

// Number of bits in the input word
// Any value of 2 or more is supported by the controller and datapath
`define BIT_DIFF_WIDTH 16

// The difference spans minus width up to plus width
// That is 2*width + 1 distinct values including zero
// Width 16 needs 6 bits, which covers -32 to +31
`define BIT_DIFF_RESULT_WIDTH $clog2(2 * `BIT_DIFF_WIDTH + 1)

// Both macros are consumed by bit_diff_pkg to form the data,
// result and counter types

`endif

//--- rtl/bit_diff_pkg.sv
`include "bit_diff_params.svh"

////////////////////////////////////////////////////////////
// Data and operation types for the bit-difference datapath
////////////////////////////////////////////////////////////

package bit_diff_pkg;

   // Input word as presented on the data port
   typedef logic [`BIT_DIFF_WIDTH-1:0] data_t;

   // Signed running difference and final result
   // Both share one type so the capture path has no width change
   typedef logic signed [`BIT_DIFF_RESULT_WIDTH-1:0] result_t;

   // Counter over the bit positions, 0 up to width minus one
   // No extra bit is needed since completion is detected at width minus one
   typedef logic [$clog2(`BIT_DIFF_WIDTH)-1:0] count_t;

   // Operations the controller issues to the datapath
   // DP_LOAD clears the difference and counter and takes a new word
   // DP_STEP consumes one bit from the bottom of the data register
   typedef enum logic {
      DP_LOAD = 1'b0,
      DP_STEP = 1'b1
   } dp_op_t;

endpackage

//--- rtl/bit_diff_ctrl_pkg.sv
`include "bit_diff_params.svh"

////////////////////////////////////////////////////////////
// Controller state encoding
////////////////////////////////////////////////////////////

package bit_diff_ctrl_pkg;

   // START is the idle state left by reset, with done low
   // COMPUTE walks through the data bits, one per clock
   // RESTART holds the finished result with done high
   // START and RESTART behave alike apart from done, so a new go
   // is taken from either one
   // The fourth code of the two-bit encoding is never entered
   typedef enum logic [1:0] {
      START   = 2'd0,
      COMPUTE = 2'd1,
      RESTART = 2'd2
   } ctrl_state_t;

endpackage

//--- rtl/bit_diff_controller.sv
`timescale 1ns/1ps

`include "bit_diff_params.svh"

// Three-state controller for the bit-difference calculator
// It owns no data, it only decides which operation the datapath
// performs on each clock and when the result register loads
module bit_diff_controller (
   input  logic                clk,
   input  logic                rst,
   input  logic                go,
   input  logic                count_done,
   output bit_diff_pkg::dp_op_t op,
   output logic                capture,
   output logic                done
);

   import bit_diff_pkg::*;
   import bit_diff_ctrl_pkg::*;

   ////////////////////////////////////////////////////////////
   // State register
   ////////////////////////////////////////////////////////////

   ctrl_state_t state_r;
   ctrl_state_t next_state;

   // Reset drops the machine into START with done low
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_r <= START;
      end
      else begin
         state_r <= next_state;
      end
   end

   ////////////////////////////////////////////////////////////
   // Next state and datapath control
   ////////////////////////////////////////////////////////////

   // Every output here depends only on the state and count_done,
   // so nothing is delayed by an extra cycle and go never reaches
   // done through logic
   always_comb begin
      // Defaults keep the datapath loading and the result held
      next_state = state_r;
      op         = DP_LOAD;
      capture    = 1'b0;
      done       = 1'b0;

      case (state_r)
         START : begin
            // Idle after reset
            // The datapath keeps loading the data port on every edge,
            // so the word present at the accepting edge is the one used
            op = DP_LOAD;
            if (go) begin
               next_state = COMPUTE;
            end
         end

         COMPUTE : begin
            // One bit per clock is consumed by the datapath
            // go is ignored here since only one item is in flight
            op = DP_STEP;

            // On the last bit the updated difference goes straight into
            // the result register, at the same edge that enters RESTART
            if (count_done) begin
               capture    = 1'b1;
               next_state = RESTART;
            end
         end

         RESTART : begin
            // Result is valid and stays so until the next go
            done = 1'b1;

            // Same loading behaviour as START so a held go runs
            // computations back to back
            op = DP_LOAD;
            if (go) begin
               next_state = COMPUTE;
            end
         end

         default : begin
            // Unused encoding, recover to idle
            next_state = START;
         end
      endcase
   end

   // Timing seen from outside
   // The edge that accepts go moves the state to COMPUTE
   // The machine then spends width edges in COMPUTE
   // The last of them captures the result and enters RESTART
   // So done rises width plus one edges after the accepting edge
   // and drops right after the edge that accepts the next go

endmodule

//--- rtl/bit_diff_datapath.sv
`timescale 1ns/1ps

`include "bit_diff_params.svh"

// Behavioural datapath for the bit-difference calculator
// Holds the shifting copy of the data word, the signed running
// difference, the bit counter and the result register
module bit_diff_datapath (
   input  logic                   clk,
   input  logic                   rst,
   input  bit_diff_pkg::data_t    data,
   input  bit_diff_pkg::dp_op_t   op,
   input  logic                   capture,
   output logic                   count_done,
   output bit_diff_pkg::result_t  result
);

   import bit_diff_pkg::*;

   ////////////////////////////////////////////////////////////
   // Registers
   ////////////////////////////////////////////////////////////

   data_t   data_r;
   result_t diff_r;
   count_t  count_r;
   result_t result_r;

   ////////////////////////////////////////////////////////////
   // Arithmetic and select logic
   ////////////////////////////////////////////////////////////

   // Updated difference for the bit currently at the bottom
   result_t diff_update;

   // Values each register takes at the next edge
   data_t   data_mux;
   result_t diff_mux;
   count_t  count_mux;

   // A one adds to the difference and a zero takes one away
   assign diff_update = data_r[0] ? diff_r + result_t'(1)
                                  : diff_r - result_t'(1);

   // Load takes the word on the data port and clears the difference
   // and the counter, step consumes one bit per clock
   always_comb begin
      if (op == DP_LOAD) begin
         data_mux  = data;
         diff_mux  = '0;
         count_mux = '0;
      end
      else begin
         // Shift the consumed bit out of the bottom
         data_mux  = data_r >> 1;
         diff_mux  = diff_update;
         count_mux = count_r + count_t'(1);
      end
   end

   // Counter sits at width minus one during the last bit
   // The comparison constant folds, so this is a plain equality
   assign count_done = (count_r == count_t'(`BIT_DIFF_WIDTH - 1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         data_r   <= '0;
         diff_r   <= '0;
         count_r  <= '0;
         result_r <= '0;
      end
      else begin
         data_r  <= data_mux;
         diff_r  <= diff_mux;
         count_r <= count_mux;

         // Capture comes on the last compute cycle, and the result
         // takes the already updated difference, so the final bit is
         // included without a correction step afterwards
         if (capture) begin
            result_r <= diff_update;
         end
      end
   end

   // Result holds between captures, including while a new word
   // is being processed
   assign result = result_r;

endmodule

//--- rtl/bit_diff.sv
`timescale 1ns/1ps

`include "bit_diff_params.svh"

// Top level of the bit-difference calculator
// Result equals twice the number of one bits minus the width,
// valid while done is high
module bit_diff (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  go,
   input  bit_diff_pkg::data_t   data,
   output bit_diff_pkg::result_t result,
   output logic                  done
);

   import bit_diff_pkg::*;

   ////////////////////////////////////////////////////////////
   // Controller to datapath wiring
   ////////////////////////////////////////////////////////////

   // Operation chosen by the controller for each clock
   dp_op_t op;

   // Loads the result register on the last compute cycle
   logic   capture;

   // Raised by the datapath while the last bit is being consumed
   logic   count_done;

   // FSM that sequences the computation and produces done
   bit_diff_controller u_controller (
      .clk        (clk),
      .rst        (rst),
      .go         (go),
      .count_done (count_done),
      .op         (op),
      .capture    (capture),
      .done       (done)
   );

   // Datapath doing the shifting, counting and accumulation
   bit_diff_datapath u_datapath (
      .clk        (clk),
      .rst        (rst),
      .data       (data),
      .op         (op),
      .capture    (capture),
      .count_done (count_done),
      .result     (result)
   );

endmodule

//--- testbench/bit_diff_properties.sv
`timescale 1ns/1ps

`include "bit_diff_params.svh"

// Protocol checks on the go/done handshake of the bit-difference
// calculator, attached to the top level with bind
module bit_diff_properties (
   input logic                          clk,
   input logic                          rst,
   input logic                          go,
   input logic                          done,
   input bit_diff_pkg::result_t         result,
   input bit_diff_pkg::count_t          count,
   input bit_diff_ctrl_pkg::ctrl_state_t state
);

   import bit_diff_pkg::*;
   import bit_diff_ctrl_pkg::*;

   // go only counts where the controller is able to take it
   logic accept;

   assign accept = go && (state == START || state == RESTART);

   ////////////////////////////////////////////////////////////
   // Handshake
   ////////////////////////////////////////////////////////////

   // A go seen while the result is on offer starts the next word,
   // so done must be gone one edge later
   done_drops_after_go : assert property (
      @(posedge clk) disable iff (rst)
      (go && done) |=> !done
   ) else $error("done stayed high after go was accepted");

   // Nothing may touch the result register while done is shown
   result_held_with_done : assert property (
      @(posedge clk) disable iff (rst)
      done |=> (!done || $stable(result))
   ) else $error("result changed while done stayed high");

   // done rises only width plus one edges after acceptance, counting
   // the accepting edge, and only out of the last compute cycle
   done_rises_on_time : assert property (
      @(posedge clk) disable iff (rst)
      $rose(done) |-> ($past(accept, `BIT_DIFF_WIDTH + 1) &&
                       $past(state) == COMPUTE &&
                       $past(count) == count_t'(`BIT_DIFF_WIDTH - 1))
   ) else $error("done rose at the wrong distance from go");

   // The unused fourth state code is never entered
   state_is_legal : assert property (
      @(posedge clk) disable iff (rst)
      state inside {START, COMPUTE, RESTART}
   ) else $error("controller state left the legal encodings");

endmodule

bind bit_diff bit_diff_properties u_properties (
   .clk    (clk),
   .rst    (rst),
   .go     (go),
   .done   (done),
   .result (result),
   .count  (u_datapath.count_r),
   .state  (u_controller.state_r)
);

//--- testbench/bit_diff_tb.sv
`timescale 1ns/1ps

`include "bit_diff_params.svh"

// Directed testbench for the bit-difference calculator
module bit_diff_tb;

   import bit_diff_pkg::*;

   ////////////////////////////////////////////////////////////
   // Run length and limits
   ////////////////////////////////////////////////////////////

   localparam int NUM_RANDOM    = 200;
   localparam int NUM_DISTURBED = 10;

   // Edges from acceptance to done, the accepting edge counted as one
   localparam int LATENCY_EDGES = `BIT_DIFF_WIDTH + 1;

   // Each word costs about width plus three cycles, with headroom for
   // corner words, back to back runs and reset
   localparam int EST_CYCLES     = (NUM_RANDOM + NUM_DISTURBED + 20) * (`BIT_DIFF_WIDTH + 3);
   localparam int TIMEOUT_CYCLES = (2 * EST_CYCLES > 10000) ? 2 * EST_CYCLES : 10000;

   logic    clk;
   logic    rst;
   logic    go;
   data_t   data;
   result_t result;
   logic    done;
   int      cycle_count = 0;

   bit_diff uut (
      .clk    (clk),
      .rst    (rst),
      .go     (go),
      .data   (data),
      .result (result),
      .done   (done)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Hard stop in case done never comes back
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, the tests never finished", cycle_count);
         $display("Errors found");
         $fatal(1, "Run exceeded its cycle limit");
      end
   end

   ////////////////////////////////////////////////////////////
   // Reference model and checking
   ////////////////////////////////////////////////////////////

   // Twice the number of one bits minus the width
   function automatic int expected_difference(input data_t word);
      int ones;
      int i;
      ones = 0;
      for (i = 0; i < `BIT_DIFF_WIDTH; i++) begin
         if (word[i]) begin
            ones++;
         end
      end
      return 2 * ones - `BIT_DIFF_WIDTH;
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("MISMATCH %s: actual 0x%08h expected 0x%08h", name, actual, expected);
         $display("Errors found");
         $fatal(1, "Check on %s failed", name);
      end
   endtask

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Errors found");
      $fatal(1, "%s", reason);
   endtask

   ////////////////////////////////////////////////////////////
   // Handshake helpers
   ////////////////////////////////////////////////////////////

   // Called at the falling edge just after the accepting edge
   // Returns at the falling edge where done is first seen high
   // With disturb set, go and data toggle at random while computing
   task automatic wait_done(input logic disturb);
      int edges_seen;
      edges_seen = 1;
      check_value("done", 32'(done), 32'd0);
      while (done !== 1'b1) begin
         if (disturb) begin
            go   = 1'($urandom);
            data = data_t'({$urandom, $urandom});
         end
         @(negedge clk);
         edges_seen++;
         if (done !== 1'b1 && edges_seen >= LATENCY_EDGES) begin
            abort_run($sformatf("done did not rise within %0d cycles of go", LATENCY_EDGES));
         end
      end
      if (edges_seen != LATENCY_EDGES) begin
         abort_run($sformatf("done rose %0d cycles after go, expected %0d",
                             edges_seen, LATENCY_EDGES));
      end
   endtask

   task automatic run_word(input data_t word, input logic disturb);
      data = word;
      go   = 1'b1;
      @(negedge clk);
      go = 1'b0;
      wait_done(disturb);
      go = 1'b0;
      check_value("result", 32'(result), 32'(expected_difference(word)));
   endtask

   ////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////

   task automatic test_reset_state();
      int i;
      for (i = 0; i < 4; i++) begin
         check_value("done", 32'(done), 32'd0);
         check_value("result", 32'(result), 32'd0);
         @(negedge clk);
      end
   endtask

   task automatic test_corner_words();
      data_t alt;
      int i;
      for (i = 0; i < `BIT_DIFF_WIDTH; i++) begin
         alt[i] = (i % 2 == 1);
      end
      run_word('0, 1'b0);
      run_word('1, 1'b0);
      run_word(alt, 1'b0);
      run_word(~alt, 1'b0);
      run_word(data_t'(1), 1'b0);
      run_word(data_t'(1) << (`BIT_DIFF_WIDTH - 1), 1'b0);
   endtask

   task automatic test_random_words();
      int n;
      for (n = 0; n < NUM_RANDOM; n++) begin
         run_word(data_t'({$urandom, $urandom}), 1'b0);
      end
   endtask

   // go pulses and data noise during COMPUTE must be ignored
   task automatic test_ignored_go();
      int n;
      for (n = 0; n < NUM_DISTURBED; n++) begin
         run_word(data_t'({$urandom, $urandom}), 1'b1);
      end
   endtask

   // go stays high, so each done is followed at once by a new word
   task automatic test_back_to_back();
      data_t words [3];
      int k;
      words[0] = data_t'({$urandom, $urandom});
      words[1] = '1;
      words[2] = data_t'({$urandom, $urandom});
      go = 1'b1;
      for (k = 0; k < 3; k++) begin
         data = words[k];
         @(negedge clk);
         if (k > 0) begin
            // Old result stays in place while the next word runs
            check_value("result", 32'(result), 32'(expected_difference(words[k-1])));
         end
         wait_done(1'b0);
         check_value("result", 32'(result), 32'(expected_difference(words[k])));
      end
      go = 1'b0;
   endtask

   initial begin
      void'($urandom(32'h55aa_9771));
      rst  = 1'b1;
      go   = 1'b0;
      data = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      test_reset_state();
      test_corner_words();
      test_random_words();
      test_ignored_go();
      test_back_to_back();

      $display("No errors");
      $finish;
   end

endmodule

//--- bit_diff.f
+incdir+include
rtl/bit_diff_pkg.sv
rtl/bit_diff_ctrl_pkg.sv
rtl/bit_diff_controller.sv
rtl/bit_diff_datapath.sv
rtl/bit_diff.sv
testbench/bit_diff_properties.sv
testbench/bit_diff_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the bit_diff testbench with Verilator.
# Exits 0 only when the simulation prints its pass message.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=bit_diff_sim

verilator --binary --timing --assert \
   -f bit_diff.f \
   --top-module bit_diff_tb \
   -Mdir "$BUILD_DIR" \
   -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$("./$BUILD_DIR/$SIM_BIN" 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi
